// File: periphTrace.txt
# op name a b c, hex fields: W addr data | R addr expect | M addr min max of diff to last read
# S byte stop | L on | I gpioIn | P gpioOut gpioDir | D cycles, unused fields are 0
W ack 3c deadbeef 0
R ack 3c 0 0
R ack 08 0 0
R ack 14 0 0
R ack 18 4 0
W gpio 28 0000ffff 0
W gpio 24 12345678 0
P gpio 12345678 0000ffff 0
W gpio 30 f0000000 0
W gpio 34 00000078 0
P gpio f2345600 0000ffff 0
R gpio 24 f2345600 0
R gpio 28 0000ffff 0
I gpio cafe0123 0 0
D gpio 4 0 0
R gpio 20 cafe0123 0
M timer 00 0 ffffffff
D timer 1388 0 0
M timer 00 62 67
R timer 04 0 0
L loopback 1 0 0
W loopback 14 41 0
W loopback 14 42 0
W loopback 14 43 0
D loopback 4b0 0 0
R loopback 18 5 0
R loopback 10 41 0
R loopback 10 42 0
R loopback 10 43 0
R loopback 18 4 0
L loopback 0 0 0
S framing a5 0 0
R framing 18 5 0
R framing 10 1a5 0
S overflow 01 1 0
S overflow 02 1 0
S overflow 03 1 0
S overflow 04 1 0
S overflow 05 1 0
S overflow 06 1 0
S overflow 07 1 0
S overflow 08 1 0
S overflow 09 1 0
R overflow 18 7 0
R overflow 10 01 0
R overflow 10 02 0
R overflow 10 03 0
R overflow 10 04 0
R overflow 10 05 0
R overflow 10 06 0
R overflow 10 07 0
R overflow 10 08 0
R overflow 18 4 0

// File: vlog.f
periphPkg.sv
tickTimer.sv
byteQueue.sv
uartTx.sv
uartRx.sv
busRegs.sv
mmioPeriph.sv
periphTb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = periphTb
FILELIST  = vlog.f
LOG       = sim.log
PASSMSG   = Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: periphTb.sv
// peripheral testbench, replays the trace file against the bus, serial line and GPIO pins
`timescale 1ns/1ns

module periphTb import periphPkg::*;
();

	localparam int BIT_CLOCKS = SAMPLE_DIV * OVERSAMPLE;
	localparam int ACK_WAIT = 8;
	localparam int RESET_CYCLES = 16;

	logic clock = 1'b0;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] datIn;
	logic [3:0] sel;
	logic ack;
	logic [DATA_W-1:0] datOut;
	logic uartTxd;
	logic uartRxd = 1'b1;
	logic [31:0] gpioIn;
	logic [31:0] gpioOut;
	logic [31:0] gpioDir;

	// serial line model
	logic loopback = 1'b0;
	logic lineLevel = 1'b1;
	logic txdSeen = 1'b1;

	// trace contents, one entry per line
	byte opQ[$];
	string nameQ[$];
	logic [31:0] argA[$];
	logic [31:0] argB[$];
	logic [31:0] argC[$];

	int errorCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int testChecks = 0;
	int testErrors = 0;
	string testName = "";
	logic [31:0] lastRead = '0;
	int cycleCount = 0;
	int cycleLimit = 0;

	mmioPeriph i_dut (
		.clock(clock),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.sel(sel),
		.ack(ack),
		.datOut(datOut),
		.uartTxd(uartTxd),
		.uartRxd(uartRxd),
		.gpioIn(gpioIn),
		.gpioOut(gpioOut),
		.gpioDir(gpioDir)
	);

	always #10 clock = ~clock;

	// txd taken mid-cycle so the loopback path has no edge race
	always @(negedge clock)
		txdSeen <= uartTxd;

	always @(posedge clock)
		uartRxd <= loopback ? txdSeen : lineLevel;

	function automatic bit loadTrace();
		int fd;
		int fields;
		string line;
		string op;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		bit ok;
		ok = 1'b1;
		fd = $fopen("periphTrace.txt", "r");
		if (fd == 0)
			return 1'b0;
		while ($fgets(line, fd) != 0)
		begin
			fields = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
			// blank and comment lines are skipped
			if (fields > 0 && op.getc(0) != "#")
			begin
				if (fields == 5)
				begin
					opQ.push_back(op.getc(0));
					nameQ.push_back(name);
					argA.push_back(a);
					argB.push_back(b);
					argC.push_back(c);
				end
				else
				begin
					$display("malformed trace line: %s", line);
					ok = 1'b0;
				end
			end
		end
		$fclose(fd);
		return ok && (opQ.size() > 0);
	endfunction

	// cycle budget for the whole trace
	function automatic int traceBudget();
		int budget;
		budget = RESET_CYCLES + 200;
		foreach (opQ[i])
		begin
			case (opQ[i])
				"D": budget += int'(argA[i]);
				"S": budget += 400;
				"W", "R", "M": budget += 20;
				default: budget += 2;
			endcase
		end
		return budget;
	endfunction

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		testChecks++;
		assert (actual === expected)
		else
		begin
			$display("mismatch %s: expected %h, actual %h", what, expected, actual);
			noteError();
		end
	endtask

	task automatic checkRange(input string what, input logic [31:0] low,
			input logic [31:0] high, input logic [31:0] actual);
		checkCount++;
		testChecks++;
		assert (actual >= low && actual <= high)
		else
		begin
			$display("mismatch %s: expected %h..%h, actual %h", what, low, high, actual);
			noteError();
		end
	endtask

	// one Wishbone classic access, counts ack pulses until one cycle after release
	task automatic busAccess(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		int pulses;
		rdata = '0;
		waited = 0;
		pulses = 0;
		@(posedge clock);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= write;
		adr <= addr;
		datIn <= data;
		sel <= 4'hf;
		while (pulses == 0 && waited < ACK_WAIT)
		begin
			@(negedge clock);
			waited++;
			if (ack)
			begin
				pulses++;
				rdata = datOut;
			end
		end
		@(posedge clock);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		@(negedge clock);
		if (ack)
			pulses++;
		assert (pulses == 1)
		else
		begin
			if (pulses == 0)
				$display("test %s: no ack from the bus at offset %h", testName, addr);
			else
				$display("test %s: more than one ack at offset %h", testName, addr);
			noteError();
		end
	endtask

	task automatic busRead(input logic [ADDR_W-1:0] addr, output logic [31:0] value);
		busAccess(1'b0, addr, '0, value);
		lastRead = value;
	endtask

	task automatic holdLine(input logic level);
		@(posedge clock);
		lineLevel <= level;
		repeat (BIT_CLOCKS - 1) @(posedge clock);
	endtask

	// 8N1 frame, LSB first, then one idle bit
	task automatic sendSerial(input logic [7:0] value, input logic stopBit);
		logic [9:0] frame;
		frame = {stopBit, value, 1'b0};
		for (int i = 0; i < 10; i++)
			holdLine(frame[i]);
		holdLine(1'b1);
	endtask

	task automatic finishTest();
		if (testName != "")
		begin
			testsRun++;
			if (testErrors != 0)
			begin
				testsFailed++;
				$display("test %s: failed, %0d checks, %0d errors", testName, testChecks,
					testErrors);
			end
			else
				$display("test %s: ok, %0d checks", testName, testChecks);
		end
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic runStep(input int i);
		logic [31:0] value;
		logic [31:0] prev;
		case (opQ[i])
			"W": busAccess(1'b1, argA[i][ADDR_W-1:0], argB[i], value);
			"R":
			begin
				busRead(argA[i][ADDR_W-1:0], value);
				checkValue(nameQ[i], argB[i], value);
			end
			"M":
			begin
				// difference from the previous bus read
				prev = lastRead;
				busRead(argA[i][ADDR_W-1:0], value);
				checkRange(nameQ[i], argB[i], argC[i], value - prev);
			end
			"S": sendSerial(argA[i][7:0], argB[i][0]);
			"L":
			begin
				@(posedge clock);
				loopback <= argA[i][0];
			end
			"I":
			begin
				@(posedge clock);
				gpioIn <= argA[i];
			end
			"P":
			begin
				@(negedge clock);
				checkValue({nameQ[i], " gpioOut"}, argA[i], gpioOut);
				checkValue({nameQ[i], " gpioDir"}, argB[i], gpioDir);
			end
			"D": repeat (int'(argA[i])) @(posedge clock);
			default:
			begin
				$display("test %s: unknown trace op %c", nameQ[i], opQ[i]);
				noteError();
			end
		endcase
	endtask

	// watchdog
	initial
	begin
		while (cycleLimit == 0 || cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout after %0d cycles, trace did not complete", cycleCount);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		sel = '0;
		gpioIn = '0;
		if (loadTrace())
		begin
			cycleLimit = traceBudget();
			repeat (RESET_CYCLES) @(posedge clock);
			rst <= 1'b0;
			foreach (opQ[i])
			begin
				if (nameQ[i] != testName)
				begin
					finishTest();
					testName = nameQ[i];
				end
				runStep(i);
			end
			finishTest();
		end
		else
		begin
			$display("cannot read a valid trace from periphTrace.txt");
			errorCount++;
		end
		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d", testsRun,
			testsRun - testsFailed, testsFailed, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: mmioPeriph.sv
// memory-mapped peripheral top with timer, UART and GPIO behind a Wishbone slave
`timescale 1ns/1ns

module mmioPeriph import periphPkg::*;
(
	input logic clock,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [ADDR_W-1:0] adr,
	input logic [DATA_W-1:0] datIn,
	input logic [3:0] sel,
	output logic ack,
	output logic [DATA_W-1:0] datOut,
	output logic uartTxd,
	input logic uartRxd,
	input logic [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir
);

	logic [63:0] usCount;
	logic sampleTick;
	logic txPush;
	logic [7:0] txData;
	logic [7:0] txHead;
	logic txPop;
	logic txFull;
	logic txEmpty;
	logic rxPush;
	rxEntry_t rxEntry;
	rxEntry_t rxHead;
	logic rxPop;
	logic rxFull;
	logic rxEmpty;

	tickTimer timer (.clock, .rst, .usCount, .sampleTick);

	// transmit path holds plain bytes
	byteQueue #(.entry_t(logic [7:0])) txQueue (
		.clock, .rst,
		.push(txPush), .pushData(txData),
		.pop(txPop), .popData(txHead),
		.full(txFull), .empty(txEmpty)
	);

	// receive path carries the framing flag with each byte
	byteQueue #(.entry_t(rxEntry_t)) rxQueue (
		.clock, .rst,
		.push(rxPush), .pushData(rxEntry),
		.pop(rxPop), .popData(rxHead),
		.full(rxFull), .empty(rxEmpty)
	);

	uartTx txSeq (
		.clock, .rst, .sampleTick,
		.qData(txHead), .qEmpty(txEmpty), .qPop(txPop),
		.txd(uartTxd)
	);

	uartRx rxSeq (
		.clock, .rst, .sampleTick,
		.rxd(uartRxd), .qFull(rxFull),
		.qPush(rxPush), .qData(rxEntry)
	);

	busRegs regs (
		.clock, .rst,
		.cyc, .stb, .we, .adr, .datIn, .sel, .ack, .datOut,
		.usCount,
		.txFull, .txEmpty, .txPush, .txData,
		.rxEmpty, .rxFull, .rxHead, .rxPop,
		.gpioIn, .gpioOut, .gpioDir
	);

endmodule

// File: busRegs.sv
// Wishbone classic register slave for timer, UART queues and GPIO
`timescale 1ns/1ns

module busRegs import periphPkg::*;
(
	input logic clock,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [ADDR_W-1:0] adr,
	input logic [DATA_W-1:0] datIn,
	input logic [3:0] sel,
	output logic ack,
	output logic [DATA_W-1:0] datOut,
	input logic [63:0] usCount,
	input logic txFull,
	input logic txEmpty,
	output logic txPush,
	output logic [7:0] txData,
	input logic rxEmpty,
	input logic rxFull,
	input rxEntry_t rxHead,
	output logic rxPop,
	input logic [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir
);

	logic request;
	logic isRead;
	logic isWrite;
	logic [DATA_W-1:0] byteMask;
	logic [DATA_W-1:0] writeBits;
	logic [DATA_W-1:0] readData;
	logic [31:0] timerHiSnap;
	logic [31:0] gpioMeta;
	logic [31:0] gpioSync;

	// new access, not yet acknowledged
	assign request = cyc && stb && !ack;
	assign isRead = request && !we;
	assign isWrite = request && we;
	assign byteMask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	assign writeBits = datIn & byteMask;

	always_comb
	begin
		readData = '0;
		case (adr)
			REG_TIMER_LO: readData = usCount[31:0];
			REG_TIMER_HI: readData = timerHiSnap;
			REG_UART_RX:
				if (!rxEmpty)
					readData = {23'd0, rxHead.frameErr, rxHead.data};
			REG_UART_STAT: readData = {28'd0, txFull, txEmpty, rxFull, !rxEmpty};
			REG_GPIO_IN: readData = gpioSync;
			REG_GPIO_OUT: readData = gpioOut;
			REG_GPIO_DIR: readData = gpioDir;
			REG_GPIO_SET: readData = gpioOut;
			REG_GPIO_CLR: readData = gpioOut;
			default: readData = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			txPush <= 1'b0;
			rxPop <= 1'b0;
			timerHiSnap <= '0;
			gpioOut <= '0;
			gpioDir <= '0;
		end
		else
		begin
			ack <= request;
			// queue strobes sit on the ack cycle, one per access
			txPush <= isWrite && (adr == REG_UART_TX) && sel[0] && !txFull;
			rxPop <= isRead && (adr == REG_UART_RX) && !rxEmpty;
			// high word frozen with the low word for a coherent 64-bit read
			if (isRead && adr == REG_TIMER_LO)
				timerHiSnap <= usCount[63:32];
			if (isWrite)
			begin
				case (adr)
					REG_GPIO_OUT: gpioOut <= (gpioOut & ~byteMask) | writeBits;
					REG_GPIO_DIR: gpioDir <= (gpioDir & ~byteMask) | writeBits;
					REG_GPIO_SET: gpioOut <= gpioOut | writeBits;
					REG_GPIO_CLR: gpioOut <= gpioOut & ~writeBits;
					default: gpioOut <= gpioOut;
				endcase
			end
		end
	end

	always_ff @(posedge clock)
	begin
		gpioMeta <= gpioIn;
		gpioSync <= gpioMeta;
		// writes return zero
		if (request)
			datOut <= isRead ? readData : '0;
		if (isWrite && adr == REG_UART_TX)
			txData <= datIn[7:0];
	end

	// every ack answers a request seen the cycle before
	ackNeedsRequest: assert property (@(posedge clock) disable iff (rst)
		$rose(ack) |-> $past(cyc && stb));

endmodule

// File: uartRx.sv
// UART receive sequencer, finds start edges, samples mid-bit and checks the stop bit
`timescale 1ns/1ns

module uartRx import periphPkg::*;
(
	input logic clock,
	input logic rst,
	input logic sampleTick,
	input logic rxd,
	input logic qFull,
	output logic qPush,
	output rxEntry_t qData
);

	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_t;

	rxState_t state;
	logic rxMeta;
	logic rxSync;
	logic rxLast;
	logic [OS_W-1:0] osCount;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic pushReq;
	rxEntry_t entry;
	logic halfDone;
	logic bitDone;

	assign halfDone = sampleTick && (osCount == OS_W'(OVERSAMPLE / 2 - 1));
	assign bitDone = sampleTick && (osCount == OS_W'(OVERSAMPLE - 1));
	// frame dropped when the receive queue has no room
	assign qPush = pushReq && !qFull;
	assign qData = entry;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end
		else
		begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= rxIdle;
			osCount <= '0;
			bitIdx <= '0;
			pushReq <= 1'b0;
		end
		else
		begin
			pushReq <= 1'b0;
			case (state)
				rxIdle:
					if (rxLast && !rxSync)
					begin
						state <= rxStart;
						osCount <= '0;
					end
				rxStart:
					// half a bit in, a high line means a glitch
					if (halfDone)
					begin
						osCount <= '0;
						bitIdx <= '0;
						state <= rxSync ? rxIdle : rxData;
					end
					else if (sampleTick)
						osCount <= osCount + 1'b1;
				rxData:
					if (bitDone)
					begin
						osCount <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= rxStop;
					end
					else if (sampleTick)
						osCount <= osCount + 1'b1;
				rxStop:
					if (bitDone)
					begin
						osCount <= '0;
						pushReq <= 1'b1;
						state <= rxIdle;
					end
					else if (sampleTick)
						osCount <= osCount + 1'b1;
				default:
					state <= rxIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == rxData && bitDone)
			shiftReg <= {rxSync, shiftReg[7:1]};
		// a low stop bit flags a framing error
		if (state == rxStop && bitDone)
		begin
			entry.data <= shiftReg;
			entry.frameErr <= !rxSync;
		end
	end

endmodule

// File: uartTx.sv
// UART transmit sequencer, sends queued bytes as 8N1 frames
`timescale 1ns/1ns

module uartTx import periphPkg::*;
(
	input logic clock,
	input logic rst,
	input logic sampleTick,
	input logic [7:0] qData,
	input logic qEmpty,
	output logic qPop,
	output logic txd
);

	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_t;

	txState_t state;
	logic [OS_W-1:0] osCount;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic bitDone;

	// last oversample tick of the current bit
	assign bitDone = sampleTick && (osCount == OS_W'(OVERSAMPLE - 1));

	// head byte taken when leaving idle or right at the end of a stop bit
	assign qPop = !qEmpty && ((state == txIdle) || (state == txStop && bitDone));

	always_comb
	begin
		case (state)
			txStart: txd = 1'b0;
			txData: txd = shiftReg[0];
			default: txd = 1'b1;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= txIdle;
			osCount <= '0;
			bitIdx <= '0;
		end
		else
		begin
			if (state != txIdle && sampleTick)
				osCount <= bitDone ? '0 : osCount + 1'b1;
			case (state)
				txIdle:
					if (!qEmpty)
						state <= txStart;
				txStart:
					if (bitDone)
					begin
						state <= txData;
						bitIdx <= '0;
					end
				txData:
					if (bitDone)
					begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= txStop;
					end
				txStop:
					// back-to-back frames when more data waits
					if (bitDone)
						state <= qEmpty ? txIdle : txStart;
				default:
					state <= txIdle;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clock)
	begin
		if (qPop)
			shiftReg <= qData;
		else if (state == txData && bitDone)
			shiftReg <= {1'b0, shiftReg[7:1]};
	end

endmodule

// File: byteQueue.sv
// byte queue: small first-word-fall-through FIFO with a type parameter for its entries
`timescale 1ns/1ns

module byteQueue import periphPkg::*;
#(
	parameter type entry_t = logic [7:0]
)
(
	input logic clock,
	input logic rst,
	input logic push,
	input entry_t pushData,
	input logic pop,
	output entry_t popData,
	output logic full,
	output logic empty
);

	entry_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(QUEUE_DEPTH));
	assign empty = (count == '0);
	// push to full and pop of empty are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;
	assign popData = mem[rdPtr];

	always_ff @(posedge clock)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	countBound: assert property (@(posedge clock) disable iff (rst)
		count <= CNT_W'(QUEUE_DEPTH));

	// a refused push or pop leaves its pointer alone next cycle
	wrPtrHold: assert property (@(posedge clock) disable iff (rst)
		!(push && !full) |=> $stable(wrPtr));
	rdPtrHold: assert property (@(posedge clock) disable iff (rst)
		!(pop && !empty) |=> $stable(rdPtr));

endmodule

// File: tickTimer.sv
// tick timer: fractional microsecond accumulator, 64-bit microsecond count and UART sample tick
`timescale 1ns/1ns

module tickTimer import periphPkg::*;
(
	input logic clock,
	input logic rst,
	output logic [63:0] usCount,
	output logic sampleTick
);

	logic [15:0] fracAcc;
	logic [15:0] fracNext;
	logic fracCarry;
	logic usStep;
	logic [DIV_W-1:0] divCount;

	// carry out of the sum marks one elapsed microsecond
	assign {fracCarry, fracNext} = {1'b0, fracAcc} + {1'b0, USEC_INC};

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			fracAcc <= '0;
			usStep <= 1'b0;
			usCount <= '0;
		end
		else
		begin
			fracAcc <= fracNext;
			usStep <= fracCarry;
			// count moves the cycle after the wrap
			if (usStep)
				usCount <= usCount + 64'd1;
		end
	end

	// down-counter for the oversample tick
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			divCount <= DIV_W'(SAMPLE_DIV - 1);
			sampleTick <= 1'b0;
		end
		else if (divCount == '0)
		begin
			divCount <= DIV_W'(SAMPLE_DIV - 1);
			sampleTick <= 1'b1;
		end
		else
		begin
			divCount <= divCount - 1'b1;
			sampleTick <= 1'b0;
		end
	end

	// both UART sequencers count ticks, so a tick must be a lone pulse
	tickIsolated: assert property (@(posedge clock) disable iff (rst)
		sampleTick |=> !sampleTick);

endmodule

// File: periphPkg.sv
// peripheral package with the register map, timing constants and the receive entry type
package periphPkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// byte offsets inside the register window
	localparam logic [ADDR_W-1:0] REG_TIMER_LO = 8'h00;
	localparam logic [ADDR_W-1:0] REG_TIMER_HI = 8'h04;
	localparam logic [ADDR_W-1:0] REG_UART_RX = 8'h10;
	localparam logic [ADDR_W-1:0] REG_UART_TX = 8'h14;
	localparam logic [ADDR_W-1:0] REG_UART_STAT = 8'h18;
	localparam logic [ADDR_W-1:0] REG_GPIO_IN = 8'h20;
	localparam logic [ADDR_W-1:0] REG_GPIO_OUT = 8'h24;
	localparam logic [ADDR_W-1:0] REG_GPIO_DIR = 8'h28;
	localparam logic [ADDR_W-1:0] REG_GPIO_SET = 8'h30;
	localparam logic [ADDR_W-1:0] REG_GPIO_CLR = 8'h34;

	// 50 MHz clock, 65536 / 1311 gives roughly 50 clocks per microsecond
	localparam logic [15:0] USEC_INC = 16'd1311;

	// short bit time for simulation: 2 clocks per tick, 16 ticks per bit
	localparam int SAMPLE_DIV = 2;
	localparam int OVERSAMPLE = 16;

	localparam int QUEUE_DEPTH = 8;

	// derived counter widths
	localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam int OS_W = $clog2(OVERSAMPLE);
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	// receive queue entry, frameErr lands in bit 8 of the UART_RX read
	typedef struct packed
	{
		logic frameErr;
		logic [7:0] data;
	} rxEntry_t;

endpackage
